//--- include/fetch_cfg.svh
// fetch front end configuration
// widths, queue depth and the RISC-V encodings the predecoder and the
// landing-pad checker look for

`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// ------------------------------------------------------------
// sizes
// ------------------------------------------------------------
// fetch address width
`define FETCH_ADDR_W 32
// entries in the fetch queue, power of two
`define FETCH_QUEUE_DEPTH 4
// landing-pad label width, bits 23 to 15 of the pad
`define LPAD_LABEL_W 9

// ------------------------------------------------------------
// opcodes
// ------------------------------------------------------------
`define OPC_BRANCH 7'b1100011
`define OPC_JAL 7'b1101111
`define OPC_JALR 7'b1100111
`define OPC_OP_IMM 7'b0010011

// fixed landing-pad fields
// mid field is bits 14 to 7, top field is bits 31 to 24
`define LPAD_MID_PATTERN 8'b1000_0000
`define LPAD_TOP_PATTERN 8'b1000_0011

`endif

//--- hdl/fetch_pkg.sv
// fetch front end types
// one instruction word with its branch, jump and landing-pad decodings,
// and the entry that travels from the PC generator to the back end

`default_nettype none

`include "fetch_cfg.svh"

package fetch_pkg;

    // conditional branch, B-type immediate split over the word
    typedef struct packed {
        logic       sign;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } branch_view_t;

    // JAL and JALR share the rd position
    // J-type immediate fields only make sense for JAL
    typedef struct packed {
        logic       sign;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jump_view_t;

    // landing pad, an OP-IMM encoding with fixed fields around the label
    typedef struct packed {
        logic [7:0]               top;
        logic [`LPAD_LABEL_W-1:0] label;
        logic [7:0]               mid;
        logic [6:0]               opcode;
    } lpad_view_t;

    typedef union packed {
        branch_view_t branch;
        jump_view_t   jump;
        lpad_view_t   lpad;
    } instr_u;

    // one fetched instruction, 65 bits
    typedef struct packed {
        logic [`FETCH_ADDR_W-1:0] pc;
        instr_u                   instr;
        // static prediction said taken
        logic                     taken;
    } fetch_entry_t;

endpackage

`default_nettype wire

//--- hdl/fetch_entry_if.sv
// fetch entry channel
// one entry with a valid/ready handshake, the entry moves on an edge
// where both are high

`default_nettype none

interface fetch_entry_if
    import fetch_pkg::*;
();

    logic         valid;
    logic         ready;
    fetch_entry_t entry;

    // sender side, valid stays up with a stable entry until it moves
    modport producer (
        output valid,
        output entry,
        input  ready
    );

    // receiver side
    modport consumer (
        input  valid,
        input  entry,
        output ready
    );

endinterface

`default_nettype wire

//--- hdl/fetch_pc_gen.sv
// PC generator
// runs one four-phase request at a time on the instruction memory,
// predecodes the returned word and predicts the next PC statically
// (JAL taken, backward branch taken, everything else PC+4)
// a redirect replaces the PC and drops whatever is in flight

`default_nettype none

`include "fetch_cfg.svh"

module fetch_pc_gen
    import fetch_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic [`FETCH_ADDR_W-1:0] boot_addr_i,
    input  logic                     redirect_i,
    input  logic [`FETCH_ADDR_W-1:0] redirect_pc_i,
    output logic                     imem_req_o,
    output logic [`FETCH_ADDR_W-1:0] imem_addr_o,
    input  logic                     imem_ack_i,
    input  logic [31:0]              imem_rdata_i,
    fetch_entry_if.producer          out_o
);

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        ACK_LOW,
        HOLD
    } state_e;

    state_e                   state_q, state_d;
    logic [`FETCH_ADDR_W-1:0] pc_q, pc_d;
    logic [`FETCH_ADDR_W-1:0] addr_q;
    logic [`FETCH_ADDR_W-1:0] fetch_addr;
    logic                     boot_q;
    logic                     discard_q, discard_d;
    logic                     valid_q, valid_d;
    fetch_entry_t             entry_q;
    logic                     xfer;
    logic                     accept_rsp;

    // predecode
    instr_u                   rsp;
    logic [`FETCH_ADDR_W-1:0] imm_b, imm_j;
    logic [`FETCH_ADDR_W-1:0] next_pc;
    logic                     is_branch, is_jal, taken;

    // ------------------------------------------------------------
    // predecode and static prediction
    // ------------------------------------------------------------
    assign rsp = imem_rdata_i;

    assign imm_b = {{(`FETCH_ADDR_W-12){rsp.branch.sign}}, rsp.branch.imm11,
                    rsp.branch.imm10_5, rsp.branch.imm4_1, 1'b0};
    assign imm_j = {{(`FETCH_ADDR_W-20){rsp.jump.sign}}, rsp.jump.imm19_12,
                    rsp.jump.imm11, rsp.jump.imm10_1, 1'b0};

    assign is_branch = (rsp.branch.opcode == `OPC_BRANCH);
    assign is_jal    = (rsp.jump.opcode == `OPC_JAL);
    // backward branches are loops, guess taken
    assign taken     = is_jal | (is_branch & rsp.branch.sign);

    // JALR falls through, its target is unknown here
    assign next_pc = addr_q + (taken ? (is_jal ? imm_j : imm_b) : `FETCH_ADDR_W'(4));

    // ------------------------------------------------------------
    // handshake and next state
    // ------------------------------------------------------------
    assign xfer = valid_q & out_o.ready;

    // response is kept unless it belongs to a redirected request
    assign accept_rsp = (state_q == REQUEST) & imem_ack_i & ~discard_q & ~redirect_i;

    // redirect wins, the boot address only feeds the very first request
    assign fetch_addr = redirect_i ? redirect_pc_i : (boot_q ? boot_addr_i : pc_q);

    always_comb begin
        valid_d = valid_q;
        if (xfer) begin
            valid_d = 1'b0;
        end
        if (accept_rsp) begin
            valid_d = 1'b1;
        end
        if (redirect_i) begin
            valid_d = 1'b0;
        end
    end

    always_comb begin
        pc_d = pc_q;
        if (accept_rsp) begin
            pc_d = next_pc;
        end
        if (redirect_i) begin
            pc_d = redirect_pc_i;
        end
    end

    always_comb begin
        discard_d = discard_q;
        if (state_q == REQUEST) begin
            // req is already up, let it finish and drop the data
            if (imem_ack_i) begin
                discard_d = 1'b0;
            end else if (redirect_i) begin
                discard_d = 1'b1;
            end
        end
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: state_d = REQUEST;
            REQUEST: begin
                if (imem_ack_i) begin
                    state_d = ACK_LOW;
                end
            end
            // memory must drop ack before anything new goes out
            ACK_LOW: begin
                if (!imem_ack_i) begin
                    state_d = valid_d ? HOLD : IDLE;
                end
            end
            HOLD: begin
                if (!valid_d) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // ------------------------------------------------------------
    // registers
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= IDLE;
            pc_q      <= '0;
            boot_q    <= 1'b1;
            discard_q <= 1'b0;
            valid_q   <= 1'b0;
        end else begin
            state_q   <= state_d;
            pc_q      <= pc_d;
            discard_q <= discard_d;
            valid_q   <= valid_d;
            if (state_q == IDLE || redirect_i) begin
                boot_q <= 1'b0;
            end
        end
    end

    // address only moves when a request starts, so it is stable under req
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE) begin
            addr_q <= fetch_addr;
        end
        if (accept_rsp) begin
            entry_q.pc    <= addr_q;
            entry_q.instr <= rsp;
            entry_q.taken <= taken;
        end
    end

    assign imem_req_o  = (state_q == REQUEST);
    assign imem_addr_o = addr_q;

    assign out_o.valid = valid_q;
    assign out_o.entry = entry_q;

endmodule

`default_nettype wire

//--- hdl/fetch_queue.sv
// fetch queue
// circular buffer of fetch entries between the PC generator and the
// back end, push and pop in the same cycle, flush empties it at once

`default_nettype none

`include "fetch_cfg.svh"

module fetch_queue
    import fetch_pkg::*;
#(
    parameter int unsigned DEPTH = `FETCH_QUEUE_DEPTH
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            flush_i,
    fetch_entry_if.consumer in_i,
    fetch_entry_if.producer out_o
);

    // one pointer bit at least, so a single-entry queue still builds
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    fetch_entry_t     mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push, pop;
    logic             full, empty;

    assign full  = (count_q == CNT_W'(DEPTH));
    assign empty = (count_q == '0);

    assign push = in_i.valid & in_i.ready;
    assign pop  = out_o.valid & out_o.ready;

    // full queue stalls the producer
    assign in_i.ready = ~full;

    // head is visible the cycle after it was written
    assign out_o.valid = ~empty;
    assign out_o.entry = mem_q[rd_ptr_q];

    // ------------------------------------------------------------
    // pointers and occupancy
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // simultaneous push and pop keep the count
            unique case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_i.entry;
        end
    end

endmodule

`default_nettype wire

//--- hdl/lpad_checker.sv
// landing-pad checker
// watches entries leaving the front end, after an indirect call
// (JALR with rd x1 or x5) the next entry must be a landing pad with
// the expected label, otherwise that entry is flagged with a fault

`default_nettype none

`include "fetch_cfg.svh"

module lpad_checker
    import fetch_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic [`LPAD_LABEL_W-1:0] label_i,
    fetch_entry_if.consumer          in_i,
    output logic                     fetch_valid_o,
    input  logic                     fetch_ready_i,
    output logic [`FETCH_ADDR_W-1:0] fetch_pc_o,
    output logic [$bits(instr_u)-1:0] fetch_instr_o,
    output logic                     fetch_taken_o,
    output logic                     fetch_fault_o,
    output logic                     elp_o
);

    typedef enum logic {
        NO_LP_EXPECTED,
        LP_EXPECTED
    } lp_state_e;

    lp_state_e state_q;
    instr_u    head;
    logic      xfer;
    logic      is_call;
    logic      is_lpad;

    assign head = in_i.entry.instr;
    assign xfer = in_i.valid & fetch_ready_i;

    // indirect call, the link register is ra or t0
    assign is_call = (head.jump.opcode == `OPC_JALR) &&
                     ((head.jump.rd == 5'd1) || (head.jump.rd == 5'd5));

    // pad encoding plus a label match
    assign is_lpad = (head.lpad.opcode == `OPC_OP_IMM) &&
                     (head.lpad.mid == `LPAD_MID_PATTERN) &&
                     (head.lpad.top == `LPAD_TOP_PATTERN) &&
                     (head.lpad.label == label_i);

    // ------------------------------------------------------------
    // expectation state, moves only when an entry leaves
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= NO_LP_EXPECTED;
        end else if (flush_i) begin
            state_q <= NO_LP_EXPECTED;
        end else if (xfer) begin
            // one entry checked, pass or fail, then back to idle
            if (state_q == LP_EXPECTED) begin
                state_q <= NO_LP_EXPECTED;
            end else if (is_call) begin
                state_q <= LP_EXPECTED;
            end
        end
    end

    // straight through to the back end
    assign in_i.ready    = fetch_ready_i;
    assign fetch_valid_o = in_i.valid;
    assign fetch_pc_o    = in_i.entry.pc;
    assign fetch_instr_o = head;
    assign fetch_taken_o = in_i.entry.taken;

    assign fetch_fault_o = in_i.valid & (state_q == LP_EXPECTED) & ~is_lpad;
    assign elp_o         = (state_q == LP_EXPECTED);

endmodule

`default_nettype wire

//--- hdl/frontend_top.sv
// instruction fetch front end
// PC generator with static prediction, fetch queue and landing-pad
// checker, memory on a four-phase req/ack, entries out on valid/ready

`default_nettype none

`include "fetch_cfg.svh"

module frontend_top
    import fetch_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic [`FETCH_ADDR_W-1:0]  boot_addr_i,
    // mispredict, trap or eret merged into one target
    input  logic                      redirect_i,
    input  logic [`FETCH_ADDR_W-1:0]  redirect_pc_i,
    input  logic [`LPAD_LABEL_W-1:0]  label_i,
    // instruction memory
    output logic                      imem_req_o,
    output logic [`FETCH_ADDR_W-1:0]  imem_addr_o,
    input  logic                      imem_ack_i,
    input  logic [31:0]               imem_rdata_i,
    // back end
    output logic                      fetch_valid_o,
    input  logic                      fetch_ready_i,
    output logic [`FETCH_ADDR_W-1:0]  fetch_pc_o,
    output logic [$bits(instr_u)-1:0] fetch_instr_o,
    output logic                      fetch_taken_o,
    output logic                      fetch_fault_o,
    output logic                      elp_o
);

    fetch_entry_if pc_to_queue ();
    fetch_entry_if queue_to_chk ();

    fetch_pc_gen i_pc_gen (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .boot_addr_i   ( boot_addr_i   ),
        .redirect_i    ( redirect_i    ),
        .redirect_pc_i ( redirect_pc_i ),
        .imem_req_o    ( imem_req_o    ),
        .imem_addr_o   ( imem_addr_o   ),
        .imem_ack_i    ( imem_ack_i    ),
        .imem_rdata_i  ( imem_rdata_i  ),
        .out_o         ( pc_to_queue   )
    );

    // redirect also empties the queue
    fetch_queue i_queue (
        .clk_i   ( clk_i        ),
        .rst_ni  ( rst_ni       ),
        .flush_i ( redirect_i   ),
        .in_i    ( pc_to_queue  ),
        .out_o   ( queue_to_chk )
    );

    lpad_checker i_lpad_checker (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .flush_i       ( redirect_i    ),
        .label_i       ( label_i       ),
        .in_i          ( queue_to_chk  ),
        .fetch_valid_o ( fetch_valid_o ),
        .fetch_ready_i ( fetch_ready_i ),
        .fetch_pc_o    ( fetch_pc_o    ),
        .fetch_instr_o ( fetch_instr_o ),
        .fetch_taken_o ( fetch_taken_o ),
        .fetch_fault_o ( fetch_fault_o ),
        .elp_o         ( elp_o         )
    );

endmodule

`default_nettype wire

//--- tb/tb_frontend.sv
// testbench for the fetch front end
// random program image, random memory latency, random back-end stalls
// and occasional redirects
// every entry leaving the DUT is compared with a reference model of the
// static prediction and landing pads

`default_nettype none

`include "fetch_cfg.svh"

module tb_frontend;

    localparam int NUM_XFERS  = 2000;
    // about five cycles per fetch and up to eight while the back end stalls
    localparam int MAX_CYCLES = 20 * NUM_XFERS;
    localparam logic [`FETCH_ADDR_W-1:0] BOOT_ADDR = 32'h0000_0200;

    logic                     clk_i;
    logic                     rst_ni;
    logic [`FETCH_ADDR_W-1:0] boot_addr_i;
    logic                     redirect_i;
    logic [`FETCH_ADDR_W-1:0] redirect_pc_i;
    logic [`LPAD_LABEL_W-1:0] label_i;
    logic                     imem_req_o;
    logic [`FETCH_ADDR_W-1:0] imem_addr_o;
    logic                     imem_ack_i;
    logic [31:0]              imem_rdata_i;
    logic                     fetch_valid_o;
    logic                     fetch_ready_i;
    logic [`FETCH_ADDR_W-1:0] fetch_pc_o;
    logic [31:0]              fetch_instr_o;
    logic                     fetch_taken_o;
    logic                     fetch_fault_o;
    logic                     elp_o;

    logic [31:0] lfsr_q;
    logic [31:0] rnd;
    logic [31:0] imem [256];

    // memory responder state
    logic        req_seen;
    logic [31:0] req_addr;
    logic [1:0]  ack_delay;

    // reference model state
    logic [31:0] exp_pc;
    logic        exp_elp;
    logic [31:0] exp_instr;
    logic        exp_fault;

    int errors;
    int xfer_cnt;
    int cycle_cnt;
    int redirect_cnt;
    int pad_checks;
    int fault_cnt;

    frontend_top i_dut (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .boot_addr_i   ( boot_addr_i   ),
        .redirect_i    ( redirect_i    ),
        .redirect_pc_i ( redirect_pc_i ),
        .label_i       ( label_i       ),
        .imem_req_o    ( imem_req_o    ),
        .imem_addr_o   ( imem_addr_o   ),
        .imem_ack_i    ( imem_ack_i    ),
        .imem_rdata_i  ( imem_rdata_i  ),
        .fetch_valid_o ( fetch_valid_o ),
        .fetch_ready_i ( fetch_ready_i ),
        .fetch_pc_o    ( fetch_pc_o    ),
        .fetch_instr_o ( fetch_instr_o ),
        .fetch_taken_o ( fetch_taken_o ),
        .fetch_fault_o ( fetch_fault_o ),
        .elp_o         ( elp_o         )
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #5 clk_i = ~clk_i;
        end
    end

    // ------------------------------------------------------------
    // galois LFSR x^32+x^22+x^2+x+1 for all random numbers
    // ------------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // one LFSR step per bit and the lsb is the last bit drawn
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            r      = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return r;
    endfunction

    // ------------------------------------------------------------
    // program image
    // ------------------------------------------------------------
    function automatic logic [31:0] make_word();
        logic [31:0] r;
        logic [3:0]  kind;
        logic [31:0] mag;
        logic [31:0] off;
        logic [4:0]  rd;
        logic [8:0]  lab;
        r    = rand_bits(4);
        kind = r[3:0];
        // offsets of 4 to 64 bytes of either sign
        r    = rand_bits(5);
        mag  = {26'd0, r[3:0], 2'b00} + 32'd4;
        off  = r[4] ? -mag : mag;
        if (kind < 4'd4) begin
            r = rand_bits(22);
            return {r[21:10], r[9:5], 3'b000, r[4:0], `OPC_OP_IMM};
        end else if (kind < 4'd7) begin
            r = rand_bits(13);
            return {off[12], off[10:5], r[9:5], r[4:0], r[12:10], off[4:1], off[11],
                    `OPC_BRANCH};
        end else if (kind < 4'd9) begin
            r = rand_bits(5);
            return {off[20], off[10:1], off[11], off[19:12], r[4:0], `OPC_JAL};
        end else if (kind < 4'd12) begin
            // half of them are calls through ra or t0
            r  = rand_bits(24);
            rd = (r[1:0] == 2'd0) ? 5'd1 : ((r[1:0] == 2'd1) ? 5'd5 : r[6:2]);
            return {r[18:7], r[23:19], 3'b000, rd, `OPC_JALR};
        end else if (kind < 4'd15) begin
            // three pads in four carry the right label
            r   = rand_bits(11);
            lab = (r[1:0] != 2'd0) ? label_i : r[10:2];
            return {`LPAD_TOP_PATTERN, lab, `LPAD_MID_PATTERN, `OPC_OP_IMM};
        end
        return rand_bits(32);
    endfunction

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic logic predict_taken(input logic [31:0] w);
        return (w[6:0] == `OPC_JAL) || ((w[6:0] == `OPC_BRANCH) && w[31]);
    endfunction

    function automatic logic [31:0] predict_next(input logic [31:0] pc,
                                                 input logic [31:0] w);
        logic [31:0] imm;
        if (w[6:0] == `OPC_JAL) begin
            imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end else if ((w[6:0] == `OPC_BRANCH) && w[31]) begin
            imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end else begin
            imm = 32'd4;
        end
        return pc + imm;
    endfunction

    function automatic logic is_indirect_call(input logic [31:0] w);
        return (w[6:0] == `OPC_JALR) && ((w[11:7] == 5'd1) || (w[11:7] == 5'd5));
    endfunction

    function automatic logic is_matching_pad(input logic [31:0] w);
        return (w[6:0] == `OPC_OP_IMM) && (w[14:7] == `LPAD_MID_PATTERN) &&
               (w[31:24] == `LPAD_TOP_PATTERN) && (w[23:15] == label_i);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp);
        errors++;
    endtask

    // ------------------------------------------------------------
    // per-cycle stimulus and checks on the falling edge
    // ------------------------------------------------------------
    // four-phase slave that acks 0 to 3 cycles after req and drops ack once req falls
    task automatic respond_memory();
        if (imem_req_o) begin
            if (!req_seen) begin
                req_seen  = 1'b1;
                req_addr  = imem_addr_o;
                rnd       = rand_bits(2);
                ack_delay = rnd[1:0];
            end else if (imem_addr_o !== req_addr) begin
                report_mismatch("imem_addr_o", imem_addr_o, req_addr);
            end
            if (!imem_ack_i) begin
                if (ack_delay == 2'd0) begin
                    imem_ack_i   = 1'b1;
                    imem_rdata_i = imem[req_addr[9:2]];
                end else begin
                    ack_delay = ack_delay - 2'd1;
                end
            end
        end else begin
            imem_ack_i = 1'b0;
            req_seen   = 1'b0;
        end
    endtask

    task automatic drive_control();
        rnd        = rand_bits(6);
        redirect_i = (rnd[5:0] == 6'd0);
        if (redirect_i) begin
            rnd           = rand_bits(30);
            redirect_pc_i = {rnd[29:0], 2'b00};
        end
        // the back end takes nothing while it redirects
        // every other 256 cycles it stalls long enough to fill the queue
        rnd = rand_bits(3);
        if (cycle_cnt[8]) begin
            fetch_ready_i = (rnd[2:0] == 3'd0) && !redirect_i;
        end else begin
            fetch_ready_i = (rnd[1:0] != 2'd0) && !redirect_i;
        end
    endtask

    task automatic check_cycle();
        // elp_o reflects the transfers already made
        if (elp_o !== exp_elp) begin
            report_mismatch("elp_o", 32'(elp_o), 32'(exp_elp));
        end
        if (redirect_i) begin
            exp_pc  = redirect_pc_i;
            exp_elp = 1'b0;
            redirect_cnt++;
        end else if (fetch_valid_o && fetch_ready_i) begin
            exp_instr = imem[exp_pc[9:2]];
            exp_fault = exp_elp && !is_matching_pad(exp_instr);
            if (fetch_pc_o !== exp_pc) begin
                report_mismatch("fetch_pc_o", fetch_pc_o, exp_pc);
            end
            if (fetch_instr_o !== exp_instr) begin
                report_mismatch("fetch_instr_o", fetch_instr_o, exp_instr);
            end
            if (fetch_taken_o !== predict_taken(exp_instr)) begin
                report_mismatch("fetch_taken_o", 32'(fetch_taken_o),
                                32'(predict_taken(exp_instr)));
            end
            if (fetch_fault_o !== exp_fault) begin
                report_mismatch("fetch_fault_o", 32'(fetch_fault_o), 32'(exp_fault));
            end
            // a checked entry always ends the expectation
            if (exp_elp) begin
                pad_checks++;
                fault_cnt += int'(exp_fault);
                exp_elp = 1'b0;
            end else begin
                exp_elp = is_indirect_call(exp_instr);
            end
            exp_pc = predict_next(exp_pc, exp_instr);
            xfer_cnt++;
        end
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        lfsr_q        = 32'h325e0114;
        errors        = 0;
        xfer_cnt      = 0;
        cycle_cnt     = 0;
        redirect_cnt  = 0;
        pad_checks    = 0;
        fault_cnt     = 0;
        rst_ni        = 1'b0;
        boot_addr_i   = BOOT_ADDR;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        imem_ack_i    = 1'b0;
        imem_rdata_i  = '0;
        fetch_ready_i = 1'b0;
        rnd           = rand_bits(`LPAD_LABEL_W);
        label_i       = rnd[`LPAD_LABEL_W-1:0];
        for (int i = 0; i < 256; i++) begin
            imem[i] = make_word();
        end
        req_seen  = 1'b0;
        req_addr  = '0;
        ack_delay = '0;
        exp_pc    = BOOT_ADDR;
        exp_elp   = 1'b0;

        repeat (4) @(negedge clk_i);
        // everything quiet while reset is held
        if (imem_req_o !== 1'b0 || fetch_valid_o !== 1'b0 || elp_o !== 1'b0) begin
            $display("outputs not idle during reset at time %0t", $time);
            errors++;
        end
        rst_ni = 1'b1;

        while (xfer_cnt < NUM_XFERS && cycle_cnt < MAX_CYCLES) begin
            @(negedge clk_i);
            cycle_cnt++;
            respond_memory();
            drive_control();
            #1;
            check_cycle();
        end

        if (xfer_cnt < NUM_XFERS) begin
            $display("timeout after %0d cycles, only %0d of %0d transfers seen",
                     cycle_cnt, xfer_cnt, NUM_XFERS);
            errors++;
        end
        $display("transfers %0d, redirects %0d, pad checks %0d, faults %0d, errors %0d",
                 xfer_cnt, redirect_cnt, pad_checks, fault_cnt, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
hdl/fetch_pkg.sv
hdl/fetch_entry_if.sv
hdl/fetch_pc_gen.sv
hdl/fetch_queue.sv
hdl/lpad_checker.sv
hdl/frontend_top.sv
tb/tb_frontend.sv

//--- Makefile
# Verilator simulation of the fetch front end

VERILATOR ?= verilator
TOP       ?= tb_frontend
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
